// ==== hdl/keypad_settings.svh ====
`ifndef KEYPAD_SETTINGS_SVH
`define KEYPAD_SETTINGS_SVH

// cycles a coordinate must hold still before it counts.
`define DEBOUNCE_CYCLES 4

// key events waiting between decoder and entry.
`define EVENT_DEPTH 4

// most digits accepted before confirm.
`define ENTRY_DIGITS 4

// prescaler width, one digit slot per 2**bits cycles.
`define SCAN_DIV_BITS 2

`endif

// ==== hdl/keypad_pkg.sv ====
package keypad_pkg;

    typedef enum logic [2:0] {
        KEY_NONE      = 3'd0,
        KEY_DIGIT     = 3'd1,
        KEY_BACKSPACE = 3'd2, // "*".
        KEY_ENTER     = 3'd3, // "#".
        KEY_PAUSE     = 3'd4  // "A".
    } key_kind_e;

    typedef struct packed {
        key_kind_e  kind;
        logic [3:0] digit; // valid for KEY_DIGIT only.
    } key_event_t;

    // index 0 is the least significant digit.
    typedef logic [3:0][3:0] bcd4_t;

    typedef struct packed {
        bcd4_t      digits;
        logic [2:0] count;
        logic       paused;
    } entry_state_t;

    typedef struct packed {
        logic        strobe;
        logic [13:0] value; // up to 9999.
    } confirmed_t;

endpackage

// ==== hdl/bus_pkg.sv ====
package bus_pkg;

    typedef struct packed {
        logic        awvalid;
        logic [3:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic        bready;
        logic        arvalid;
        logic [3:0]  araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        arready;
        logic        bvalid;
        logic        rvalid;
        logic [31:0] rdata;
    } axil_rsp_t;

    localparam logic [3:0] STATUS_ADDR  = 4'h0;
    localparam logic [3:0] VALUE_ADDR   = 4'h4;
    localparam logic [3:0] DISPLAY_ADDR = 4'h8;

endpackage

// ==== hdl/key_decoder.sv ====
`timescale 1ns/1ps
`include "keypad_settings.svh"

module key_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [7:0]             key_coord,  // {row, column}, active low.
    output logic                   push,
    output keypad_pkg::key_event_t push_event
);

    localparam int DEBOUNCE = `DEBOUNCE_CYCLES;
    localparam int CNT_W = $clog2(DEBOUNCE + 1);
    localparam logic [7:0] IDLE = 8'hff;

    logic [7:0]       last_coord;
    logic [CNT_W-1:0] stable_cnt;
    logic             armed;
    logic             settled;
    keypad_pkg::key_event_t decoded;

    // sixteen keypad positions, B C D fall through to none.
    always_comb begin
        decoded.kind = keypad_pkg::KEY_DIGIT;
        decoded.digit = 4'h0;
        case (last_coord)
            8'b0111_1101: decoded.digit = 4'd0;
            8'b1110_1110: decoded.digit = 4'd1;
            8'b1110_1101: decoded.digit = 4'd2;
            8'b1110_1011: decoded.digit = 4'd3;
            8'b1101_1110: decoded.digit = 4'd4;
            8'b1101_1101: decoded.digit = 4'd5;
            8'b1101_1011: decoded.digit = 4'd6;
            8'b1011_1110: decoded.digit = 4'd7;
            8'b1011_1101: decoded.digit = 4'd8;
            8'b1011_1011: decoded.digit = 4'd9;
            8'b0111_1110: decoded.kind = keypad_pkg::KEY_BACKSPACE;
            8'b0111_1011: decoded.kind = keypad_pkg::KEY_ENTER;
            8'b1110_0111: decoded.kind = keypad_pkg::KEY_PAUSE;
            default:      decoded.kind = keypad_pkg::KEY_NONE;
        endcase
    end

    assign settled = (key_coord == last_coord) && (stable_cnt == CNT_W'(DEBOUNCE - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_coord <= IDLE;
            stable_cnt <= '0;
            armed      <= 1'b1;
            push       <= 1'b0;
        end else begin
            push <= 1'b0;
            if (key_coord != last_coord) begin
                last_coord <= key_coord;
                stable_cnt <= '0; // restart on any change.
            end else if (stable_cnt != CNT_W'(DEBOUNCE)) begin
                stable_cnt <= stable_cnt + 1'b1;
            end
            if (settled) begin
                if (last_coord == IDLE) begin
                    armed <= 1'b1; // released long enough.
                end else if (armed) begin
                    armed <= 1'b0;
                    push  <= (decoded.kind != keypad_pkg::KEY_NONE);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (settled) push_event <= decoded;
    end

endmodule

// ==== hdl/event_buffer.sv ====
`timescale 1ns/1ps

module event_buffer #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output logic     not_empty,
    output payload_t head
);

    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    payload_t          mem [depth];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_push;
    logic              do_pop;

    assign do_push   = push && (count != CNT_W'(depth)); // full drops the event.
    assign do_pop    = pop && (count != '0);
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

endmodule

// ==== hdl/keypad_entry.sv ====
`timescale 1ns/1ps
`include "keypad_settings.svh"

module keypad_entry (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     not_empty,
    input  keypad_pkg::key_event_t   head,
    output logic                     pop,
    output keypad_pkg::entry_state_t state,
    output keypad_pkg::confirmed_t   confirmed,
    output logic                     cpu_pause,
    output logic                     cpu_resume
);

    keypad_pkg::bcd4_t digits;
    logic [2:0]        count;
    logic              paused;
    logic              strobe;
    logic [13:0]       value;

    // decimal digits to binary, most significant first.
    function automatic logic [13:0] bcd_to_bin(input keypad_pkg::bcd4_t d);
        logic [13:0] acc;
        acc = '0;
        for (int i = 3; i >= 0; i--) begin
            acc = acc * 14'd10 + {10'b0, d[i]};
        end
        return acc;
    endfunction

    assign pop = not_empty; // one event per cycle.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digits     <= '0;
            count      <= '0;
            paused     <= 1'b0;
            strobe     <= 1'b0;
            cpu_pause  <= 1'b0;
            cpu_resume <= 1'b0;
        end else begin
            strobe     <= 1'b0;
            cpu_pause  <= 1'b0;
            cpu_resume <= 1'b0;
            if (pop) begin
                case (head.kind)
                    keypad_pkg::KEY_DIGIT: begin
                        if (count < 3'(`ENTRY_DIGITS)) begin
                            digits <= {digits[2:0], head.digit};
                            count  <= count + 1'b1;
                        end
                    end
                    keypad_pkg::KEY_BACKSPACE: begin
                        digits <= {4'h0, digits[3:1]};
                        if (count != '0) count <= count - 1'b1;
                    end
                    keypad_pkg::KEY_ENTER: begin
                        strobe <= 1'b1;
                        digits <= '0;
                        count  <= '0;
                    end
                    keypad_pkg::KEY_PAUSE: begin
                        paused     <= !paused;
                        cpu_pause  <= !paused;
                        cpu_resume <= paused;
                    end
                    default: ;
                endcase
            end
        end
    end

    // digits are zero when nothing was entered, so an empty confirm gives 0.
    always_ff @(posedge clk) begin
        if (pop && head.kind == keypad_pkg::KEY_ENTER) value <= bcd_to_bin(digits);
    end

    assign state.digits     = digits;
    assign state.count      = count;
    assign state.paused     = paused;
    assign confirmed.strobe = strobe;
    assign confirmed.value  = value;

endmodule

// ==== hdl/keypad_regs.sv ====
`timescale 1ns/1ps

module keypad_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  bus_pkg::axil_req_t     bus_req,
    output bus_pkg::axil_rsp_t     bus_rsp,
    input  keypad_pkg::confirmed_t confirmed,
    input  logic                   paused,
    output keypad_pkg::bcd4_t      display_value
);

    logic        bvalid;
    logic        rvalid;
    logic [31:0] rdata;
    logic        value_valid;
    logic [13:0] value;
    logic        wr_fire;
    logic        rd_fire;
    logic [31:0] rd_mux;

    // address and data are taken together.
    assign wr_fire = bus_req.awvalid && bus_req.wvalid && !bvalid;
    assign rd_fire = bus_req.arvalid && !rvalid;

    always_comb begin
        case (bus_req.araddr)
            bus_pkg::STATUS_ADDR:  rd_mux = {30'b0, paused, value_valid};
            bus_pkg::VALUE_ADDR:   rd_mux = {18'b0, value};
            bus_pkg::DISPLAY_ADDR: rd_mux = {16'b0, display_value};
            default:               rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid        <= 1'b0;
            rvalid        <= 1'b0;
            value_valid   <= 1'b0;
            display_value <= '0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
                if (bus_req.awaddr == bus_pkg::DISPLAY_ADDR) begin
                    display_value <= bus_req.wdata[15:0];
                end
            end else if (bus_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) rvalid <= 1'b1;
            else if (bus_req.rready) rvalid <= 1'b0;
            // a new value beats the clear-on-read.
            if (confirmed.strobe) begin
                value_valid <= 1'b1;
            end else if (rd_fire && bus_req.araddr == bus_pkg::VALUE_ADDR) begin
                value_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) rdata <= rd_mux;
        if (confirmed.strobe) value <= confirmed.value;
    end

    assign bus_rsp.awready = !bvalid;
    assign bus_rsp.wready  = !bvalid;
    assign bus_rsp.arready = !rvalid; // held off until r is taken.
    assign bus_rsp.bvalid  = bvalid;
    assign bus_rsp.rvalid  = rvalid;
    assign bus_rsp.rdata   = rdata;

endmodule

// ==== hdl/display_scan.sv ====
`timescale 1ns/1ps
`include "keypad_settings.svh"

module display_scan (
    input  logic                     clk,
    input  logic                     rst_n,
    input  keypad_pkg::entry_state_t state,
    input  keypad_pkg::bcd4_t        display_value,
    output logic [7:0]               seg_enable,  // active low, bit 7 is leftmost.
    output logic [3:0]               seg_digit
);

    logic [`SCAN_DIV_BITS-1:0] prescale;
    logic [2:0]                slot;
    logic [1:0]                idx;
    logic [3:0]                right_lit;
    logic                      lit;
    logic [3:0]                digit;

    // leading zeros go blank but the units digit always shows.
    always_comb begin
        right_lit[3] = (display_value[3] != 4'h0);
        for (int j = 2; j >= 1; j--) begin
            right_lit[j] = right_lit[j+1] || (display_value[j] != 4'h0);
        end
        right_lit[0] = 1'b1;
    end

    assign idx = ~slot[1:0]; // slot 0 and 4 show the top digit.

    always_comb begin
        if (!slot[2]) begin
            digit = state.digits[idx];
            lit   = ({1'b0, idx} < state.count); // only entered digits.
        end else begin
            digit = display_value[idx];
            lit   = right_lit[idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prescale   <= '0;
            slot       <= '0;
            seg_enable <= 8'hff;
        end else begin
            prescale <= prescale + 1'b1;
            if (prescale == '1) slot <= slot + 1'b1;
            seg_enable <= lit ? ~(8'h80 >> slot) : 8'hff;
        end
    end

    always_ff @(posedge clk) begin
        seg_digit <= digit;
    end

endmodule

// ==== hdl/keypad_top.sv ====
`timescale 1ns/1ps
`include "keypad_settings.svh"

module keypad_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [7:0]         key_coord,
    input  bus_pkg::axil_req_t bus_req,
    output bus_pkg::axil_rsp_t bus_rsp,
    output logic               cpu_pause,
    output logic               cpu_resume,
    output logic [7:0]         seg_enable,
    output logic [3:0]         seg_digit
);

    logic                     push;
    keypad_pkg::key_event_t   push_event;
    logic                     not_empty;
    logic                     pop;
    keypad_pkg::key_event_t   head;
    keypad_pkg::entry_state_t state;
    keypad_pkg::confirmed_t   confirmed;
    keypad_pkg::bcd4_t        display_value;

    key_decoder u_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_coord  (key_coord),
        .push       (push),
        .push_event (push_event)
    );

    event_buffer #(
        .payload_t (keypad_pkg::key_event_t),
        .depth     (`EVENT_DEPTH)
    ) u_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_event),
        .pop       (pop),
        .not_empty (not_empty),
        .head      (head)
    );

    keypad_entry u_entry (
        .clk        (clk),
        .rst_n      (rst_n),
        .not_empty  (not_empty),
        .head       (head),
        .pop        (pop),
        .state      (state),
        .confirmed  (confirmed),
        .cpu_pause  (cpu_pause),
        .cpu_resume (cpu_resume)
    );

    keypad_regs u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus_req       (bus_req),
        .bus_rsp       (bus_rsp),
        .confirmed     (confirmed),
        .paused        (state.paused),
        .display_value (display_value)
    );

    display_scan u_scan (
        .clk           (clk),
        .rst_n         (rst_n),
        .state         (state),
        .display_value (display_value),
        .seg_enable    (seg_enable),
        .seg_digit     (seg_digit)
    );

endmodule

// ==== test/tb_keypad.sv ====
`timescale 1ns/1ps

module tb_keypad;

    localparam int CMD_MARGIN = 64; // cycles per command on top of key holds.

    logic               clk = 1'b0;
    logic               rst_n;
    logic [7:0]         key_coord;
    bus_pkg::axil_req_t bus_req;
    bus_pkg::axil_rsp_t bus_rsp;
    logic               cpu_pause;
    logic               cpu_resume;
    logic [7:0]         seg_enable;
    logic [3:0]         seg_digit;

    byte         cmds[$];
    logic [31:0] arg_a[$];
    logic [31:0] arg_b[$];
    int          cycles = 0;
    int          limit = 0;
    int          pause_count = 0;
    int          resume_count = 0;

    keypad_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_coord  (key_coord),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .cpu_pause  (cpu_pause),
        .cpu_resume (cpu_resume),
        .seg_enable (seg_enable),
        .seg_digit  (seg_digit)
    );

    always #2 clk = ~clk; // 4 ns period.

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout, run went past %0d cycles", limit);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    // pulses are one cycle wide, so each is seen at exactly one falling edge.
    always @(negedge clk) begin
        if (cpu_pause) pause_count++;
        if (cpu_resume) resume_count++;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %0d ns: %s gave %h, expected %h", $time, what, got, expected);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        byte         c;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("test/keypad_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/keypad_tests.txt");
            $display("Checks failed");
            $fatal(1, "no test file");
        end else begin
            limit = 8 + CMD_MARGIN; // reset plus slack.
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h", c, a, b);
                    if (n != 3 || !(c inside {"P", "W", "R", "C", "S"})) begin
                        $display("malformed test line: %s", line);
                        $display("Checks failed");
                        $fatal(1, "bad test file");
                    end else begin
                        cmds.push_back(c);
                        arg_a.push_back(a);
                        arg_b.push_back(b);
                        limit += CMD_MARGIN + ((c == "P") ? 2 * int'(b) : 0);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // hold the key and then release it for as long.
    task automatic press(input logic [7:0] coord, input int hold);
        @(negedge clk);
        key_coord = coord;
        repeat (hold) @(negedge clk);
        key_coord = 8'hff;
        repeat (hold) @(negedge clk);
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk);
        bus_req.awvalid = 1'b1;
        bus_req.awaddr  = addr;
        bus_req.wvalid  = 1'b1;
        bus_req.wdata   = data;
        while (!(bus_rsp.awready && bus_rsp.wready)) @(negedge clk);
        @(negedge clk); // accepted at the edge just passed.
        bus_req.awvalid = 1'b0;
        bus_req.wvalid  = 1'b0;
        while (!bus_rsp.bvalid) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        @(negedge clk);
        bus_req.arvalid = 1'b1;
        bus_req.araddr  = addr;
        while (!bus_rsp.arready) @(negedge clk);
        @(negedge clk);
        bus_req.arvalid = 1'b0;
        while (!bus_rsp.rvalid) @(negedge clk);
        data = bus_rsp.rdata;
        @(negedge clk);
    endtask

    // one nibble of digits per enable bit over a full scan of 32 cycles.
    task automatic watch_scan(input logic [7:0] lit_mask, input logic [31:0] digits);
        logic [7:0] seen;
        int         k;
        seen = '0;
        repeat (32) begin
            @(negedge clk);
            if (seg_enable != 8'hff) begin
                k = 0;
                for (int i = 0; i < 8; i++) begin
                    if (!seg_enable[i]) k = i;
                end
                check("seg_enable", {24'h0, seg_enable}, {24'h0, 8'(~(8'h01 << k))});
                check($sformatf("seg_digit at bit %0d", k), {28'h0, seg_digit},
                      {28'h0, digits[4*k +: 4]});
                seen[k] = 1'b1;
            end
        end
        check("lit slots", {24'h0, seen}, {24'h0, lit_mask});
    endtask

    initial begin
        logic [31:0] data;
        rst_n          = 1'b0;
        key_coord      = 8'hff;
        bus_req        = '0;
        bus_req.bready = 1'b1;
        bus_req.rready = 1'b1;
        load_tests();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        foreach (cmds[n]) begin
            case (cmds[n])
                "P": press(arg_a[n][7:0], int'(arg_b[n]));
                "W": axi_write(arg_a[n][3:0], arg_b[n]);
                "R": begin
                    axi_read(arg_a[n][3:0], data);
                    check($sformatf("read of 0x%h", arg_a[n][3:0]), data, arg_b[n]);
                end
                "C": begin
                    check("cpu_pause pulses", pause_count, arg_a[n]);
                    check("cpu_resume pulses", resume_count, arg_b[n]);
                end
                default: watch_scan(arg_a[n][7:0], arg_b[n]);
            endcase
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== test/keypad_tests.txt ====
# cmd a b, all hex. P coord hold: key {row,col} active low, held then released hold cycles.
# W addr data: write. R addr expect: read. C pauses resumes: pulse counts. S lit digits: scan.
# 1 2 3 then confirm
P ee 8
P ed 8
P eb 8
P 7b 8
R 0 1
R 4 7b
R 0 0
# 9 8 7 6 5 stops at four digits, backspace, 4, confirm
P bb 8
P bd 8
P be 8
P db 8
P dd 8
P 7e 8
P de 8
P 7b 8
R 4 2692
R 0 0
# pause then resume
P e7 8
C 1 0
R 0 2
P e7 8
C 1 1
R 0 0
# B, D and a short tap of 1 change nothing
P d7 8
P 77 8
P ee 2
R 0 0
R 4 2692
P 7b 8
R 0 1
R 4 0
# 5 7 on the left, 0042 on the right
P dd 8
P be 8
W 8 42
R 8 42
S 33 00570042

// ==== project.f ====
+incdir+hdl
hdl/keypad_pkg.sv
hdl/bus_pkg.sv
hdl/key_decoder.sv
hdl/event_buffer.sv
hdl/keypad_entry.sv
hdl/keypad_regs.sv
hdl/display_scan.sv
hdl/keypad_top.sv
test/tb_keypad.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := tb_keypad
FILELIST := project.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

lint:
	$(SIM) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
